// ==== source/la_cfg.svh ====
// Logic analyzer register map
`ifndef LA_CFG_SVH
`define LA_CFG_SVH

// Base of the 256-byte window with only bits 31:8 decoded
`define LA_BASE_ADR 32'h2200_0000

// Data register byte offsets
`define LA_DATA_0_OFS 8'h00
`define LA_DATA_1_OFS 8'h04
`define LA_DATA_2_OFS 8'h08
`define LA_DATA_3_OFS 8'h0c

// Enable register byte offsets
`define LA_ENA_0_OFS 8'h10
`define LA_ENA_1_OFS 8'h14
`define LA_ENA_2_OFS 8'h18
`define LA_ENA_3_OFS 8'h1c

`define LA_WIDTH 128
// Output buffers disabled out of reset
`define LA_ENA_RESET 32'hffff_ffff

`endif

// ==== source/la_pkg.sv ====
// Logic analyzer types
`include "la_cfg.svh"

package la_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0] strb_t;
    typedef logic [`LA_WIDTH-1:0] probe_t;

    // AXI response code
    typedef logic [1:0] axi_resp_t;
    localparam axi_resp_t RESP_OKAY = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Bus adapter states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WRESP,
        RRESP
    } slave_state_t;

endpackage

// ==== source/axil_la_slave.sv ====
// AXI4-Lite register slave
`timescale 1ns/1ps

module axil_la_slave (
    input  logic                  clk,
    input  logic                  resetn,

    input  la_pkg::addr_t         s_awaddr_i,
    input  logic                  s_awvalid_i,
    output logic                  s_awready_o,
    input  la_pkg::word_t         s_wdata_i,
    input  la_pkg::strb_t         s_wstrb_i,
    input  logic                  s_wvalid_i,
    output logic                  s_wready_o,
    output la_pkg::axi_resp_t     s_bresp_o,
    output logic                  s_bvalid_o,
    input  logic                  s_bready_i,
    input  la_pkg::addr_t         s_araddr_i,
    input  logic                  s_arvalid_i,
    output logic                  s_arready_o,
    output la_pkg::word_t         s_rdata_o,
    output la_pkg::axi_resp_t     s_rresp_o,
    output logic                  s_rvalid_o,
    input  logic                  s_rready_i,

    output logic                  req_valid_o,
    output la_pkg::addr_t         req_addr_o,
    output la_pkg::strb_t         req_wstrb_o,
    output la_pkg::word_t         req_wdata_o,
    input  logic                  rsp_ready_i,
    input  la_pkg::word_t         rsp_rdata_i,
    input  logic                  rsp_err_i
);

    la_pkg::slave_state_t state_q;
    logic                 wr_q;
    logic                 req_valid_q;
    la_pkg::addr_t        addr_q;
    la_pkg::word_t        wdata_q;
    la_pkg::strb_t        wstrb_q;
    la_pkg::word_t        rdata_q;
    la_pkg::axi_resp_t    resp_q;
    logic                 take_write;
    logic                 take_read;

    // Address and data are only taken together and a write wins over a read
    assign take_write = (state_q == la_pkg::IDLE) && s_awvalid_i && s_wvalid_i;
    assign take_read  = (state_q == la_pkg::IDLE) && !take_write && s_arvalid_i;

    assign s_awready_o = take_write;
    assign s_wready_o  = take_write;
    assign s_arready_o = take_read;

    assign s_bvalid_o = (state_q == la_pkg::WRESP);
    assign s_bresp_o  = resp_q;
    assign s_rvalid_o = (state_q == la_pkg::RRESP);
    assign s_rresp_o  = resp_q;
    assign s_rdata_o  = rdata_q;

    assign req_valid_o = req_valid_q;
    assign req_addr_o  = addr_q;
    assign req_wstrb_o = wstrb_q;
    assign req_wdata_o = wdata_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q     <= la_pkg::IDLE;
            wr_q        <= 1'b0;
            req_valid_q <= 1'b0;
        end else begin
            // Request is a single-cycle pulse
            req_valid_q <= 1'b0;
            case (state_q)
                la_pkg::IDLE: begin
                    if (take_write) begin
                        state_q     <= la_pkg::REQ;
                        wr_q        <= 1'b1;
                        req_valid_q <= 1'b1;
                    end else if (take_read) begin
                        state_q     <= la_pkg::REQ;
                        wr_q        <= 1'b0;
                        req_valid_q <= 1'b1;
                    end
                end
                la_pkg::REQ: begin
                    if (rsp_ready_i) begin
                        state_q <= wr_q ? la_pkg::WRESP : la_pkg::RRESP;
                    end
                end
                la_pkg::WRESP: begin
                    if (s_bready_i) begin
                        state_q <= la_pkg::IDLE;
                    end
                end
                la_pkg::RRESP: begin
                    if (s_rready_i) begin
                        state_q <= la_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= la_pkg::IDLE;
                end
            endcase
        end
    end

    // Request payload and captured response
    always_ff @(posedge clk) begin
        if (take_write) begin
            addr_q  <= s_awaddr_i;
            wdata_q <= s_wdata_i;
            wstrb_q <= s_wstrb_i;
        end else if (take_read) begin
            addr_q  <= s_araddr_i;
            wdata_q <= '0;
            // No strobes on a read
            wstrb_q <= '0;
        end
        if ((state_q == la_pkg::REQ) && rsp_ready_i) begin
            rdata_q <= rsp_rdata_i;
            resp_q  <= rsp_err_i ? la_pkg::RESP_SLVERR : la_pkg::RESP_OKAY;
        end
    end

    // Responses are held until the master takes them
    property p_hold_bvalid;
        @(posedge clk) disable iff (!resetn)
        (s_bvalid_o && !s_bready_i) |=> s_bvalid_o;
    endproperty
    a_hold_bvalid: assert property (p_hold_bvalid);

    property p_hold_rvalid;
        @(posedge clk) disable iff (!resetn)
        (s_rvalid_o && !s_rready_i) |=> s_rvalid_o;
    endproperty
    a_hold_rvalid: assert property (p_hold_rvalid);

    property p_req_pulse;
        @(posedge clk) disable iff (!resetn)
        req_valid_o |=> !req_valid_o;
    endproperty
    a_req_pulse: assert property (p_req_pulse);

endmodule

// ==== source/la_regs.sv ====
// Logic analyzer register block
`timescale 1ns/1ps
`include "la_cfg.svh"

module la_regs (
    input  logic           clk,
    input  logic           resetn,

    input  logic           req_valid_i,
    input  la_pkg::addr_t  req_addr_i,
    input  la_pkg::strb_t  req_wstrb_i,
    input  la_pkg::word_t  req_wdata_i,
    output logic           rsp_ready_o,
    output la_pkg::word_t  rsp_rdata_o,
    output logic           rsp_err_o,

    input  la_pkg::probe_t probe_in_i,
    output la_pkg::probe_t probe_data_o,
    output la_pkg::probe_t probe_oen_o
);

    localparam la_pkg::addr_t BASE_ADR = `LA_BASE_ADR;

    la_pkg::word_t data_q [4];
    la_pkg::word_t ena_q [4];

    logic          base_hit;
    logic          ofs_hit;
    logic          hit;
    logic          sel_ena;
    logic [1:0]    sel_idx;
    la_pkg::word_t in_slice;
    la_pkg::word_t rd_value;

    assign probe_data_o = {data_q[3], data_q[2], data_q[1], data_q[0]};
    assign probe_oen_o  = {ena_q[3], ena_q[2], ena_q[1], ena_q[0]};

    // Offset decode inside the window
    always_comb begin
        ofs_hit = 1'b1;
        sel_ena = 1'b0;
        sel_idx = 2'd0;
        case (req_addr_i[7:0])
            `LA_DATA_0_OFS: sel_idx = 2'd0;
            `LA_DATA_1_OFS: sel_idx = 2'd1;
            `LA_DATA_2_OFS: sel_idx = 2'd2;
            `LA_DATA_3_OFS: sel_idx = 2'd3;
            `LA_ENA_0_OFS: begin
                sel_ena = 1'b1;
                sel_idx = 2'd0;
            end
            `LA_ENA_1_OFS: begin
                sel_ena = 1'b1;
                sel_idx = 2'd1;
            end
            `LA_ENA_2_OFS: begin
                sel_ena = 1'b1;
                sel_idx = 2'd2;
            end
            `LA_ENA_3_OFS: begin
                sel_ena = 1'b1;
                sel_idx = 2'd3;
            end
            default: ofs_hit = 1'b0;
        endcase
    end

    assign base_hit = (req_addr_i[31:8] == BASE_ADR[31:8]);
    assign hit      = base_hit && ofs_hit;

    // Matching 32-bit slice of the incoming user bus
    assign in_slice = probe_in_i[{sel_idx, 5'd0} +: 32];

    // Data reads see the input bus wherever the buffer is disabled
    always_comb begin
        if (!hit) begin
            rd_value = '0;
        end else if (sel_ena) begin
            rd_value = ena_q[sel_idx];
        end else begin
            rd_value = data_q[sel_idx] | (in_slice & ena_q[sel_idx]);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 4; i++) begin
                data_q[i] <= '0;
                ena_q[i]  <= `LA_ENA_RESET;
            end
        end else if (req_valid_i && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (req_wstrb_i[b]) begin
                    if (sel_ena) begin
                        ena_q[sel_idx][8*b +: 8] <= req_wdata_i[8*b +: 8];
                    end else begin
                        data_q[sel_idx][8*b +: 8] <= req_wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // One response cycle per request
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rsp_ready_o <= 1'b0;
        end else begin
            rsp_ready_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            rsp_rdata_o <= rd_value;
            rsp_err_o   <= !hit;
        end
    end

    property p_rsp_after_req;
        @(posedge clk) disable iff (!resetn)
        rsp_ready_o |-> $past(req_valid_i);
    endproperty
    a_rsp_after_req: assert property (p_rsp_after_req);

endmodule

// ==== source/la_top.sv ====
// Logic analyzer top level
`timescale 1ns/1ps

module la_top (
    input  logic              clk,
    input  logic              resetn,

    input  la_pkg::addr_t     s_awaddr_i,
    input  logic              s_awvalid_i,
    output logic              s_awready_o,
    input  la_pkg::word_t     s_wdata_i,
    input  la_pkg::strb_t     s_wstrb_i,
    input  logic              s_wvalid_i,
    output logic              s_wready_o,
    output la_pkg::axi_resp_t s_bresp_o,
    output logic              s_bvalid_o,
    input  logic              s_bready_i,
    input  la_pkg::addr_t     s_araddr_i,
    input  logic              s_arvalid_i,
    output logic              s_arready_o,
    output la_pkg::word_t     s_rdata_o,
    output la_pkg::axi_resp_t s_rresp_o,
    output logic              s_rvalid_o,
    input  logic              s_rready_i,

    input  la_pkg::probe_t    probe_in_i,
    output la_pkg::probe_t    probe_data_o,
    output la_pkg::probe_t    probe_oen_o
);

    // Register request port between adapter and register block
    logic          req_valid;
    la_pkg::addr_t req_addr;
    la_pkg::strb_t req_wstrb;
    la_pkg::word_t req_wdata;
    logic          rsp_ready;
    la_pkg::word_t rsp_rdata;
    logic          rsp_err;

    axil_la_slave u_slave (
        .clk         (clk),
        .resetn      (resetn),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .req_valid_o (req_valid),
        .req_addr_o  (req_addr),
        .req_wstrb_o (req_wstrb),
        .req_wdata_o (req_wdata),
        .rsp_ready_i (rsp_ready),
        .rsp_rdata_i (rsp_rdata),
        .rsp_err_i   (rsp_err)
    );

    la_regs u_regs (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .req_wstrb_i  (req_wstrb),
        .req_wdata_i  (req_wdata),
        .rsp_ready_o  (rsp_ready),
        .rsp_rdata_o  (rsp_rdata),
        .rsp_err_o    (rsp_err),
        .probe_in_i   (probe_in_i),
        .probe_data_o (probe_data_o),
        .probe_oen_o  (probe_oen_o)
    );

endmodule

// ==== test/la_tb_table.svh ====
// Logic analyzer test table
`ifndef LA_TB_TABLE_SVH
`define LA_TB_TABLE_SVH

typedef enum logic {OP_WR, OP_RD} op_t;

// AXI4-Lite response codes
localparam logic [1:0] RSP_OK  = 2'd0;
localparam logic [1:0] RSP_ERR = 2'd2;

localparam la_pkg::addr_t A_D0 = `LA_BASE_ADR + `LA_DATA_0_OFS;
localparam la_pkg::addr_t A_D1 = `LA_BASE_ADR + `LA_DATA_1_OFS;
localparam la_pkg::addr_t A_D2 = `LA_BASE_ADR + `LA_DATA_2_OFS;
localparam la_pkg::addr_t A_D3 = `LA_BASE_ADR + `LA_DATA_3_OFS;
localparam la_pkg::addr_t A_E0 = `LA_BASE_ADR + `LA_ENA_0_OFS;
localparam la_pkg::addr_t A_E1 = `LA_BASE_ADR + `LA_ENA_1_OFS;
localparam la_pkg::addr_t A_E2 = `LA_BASE_ADR + `LA_ENA_2_OFS;
localparam la_pkg::addr_t A_E3 = `LA_BASE_ADR + `LA_ENA_3_OFS;

// Each row holds the name, operation, address, write data, strobes, probe_in,
// expected response, read check flag and expected read data
typedef struct {
    string          name;
    op_t            op;
    la_pkg::addr_t  addr;
    la_pkg::word_t  wdata;
    la_pkg::strb_t  strb;
    la_pkg::probe_t probe;
    logic [1:0]     resp;
    bit             chk;
    la_pkg::word_t  rdata;
} row_t;

localparam int NUM_ROWS = 28;

row_t rows [NUM_ROWS] = '{
    '{"rst_d0", OP_RD, A_D0, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'h0},
    '{"rst_d1", OP_RD, A_D1, 32'h0, 4'h0, 128'ha5a5_0f0f_0000_0000,
        RSP_OK, 1'b1, 32'ha5a5_0f0f},
    '{"rst_d2", OP_RD, A_D2, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'h0},
    '{"rst_d3", OP_RD, A_D3, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'h0},
    '{"rst_e0", OP_RD, A_E0, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'hffff_ffff},
    '{"rst_e1", OP_RD, A_E1, 32'h0, 4'h0, '1, RSP_OK, 1'b1, 32'hffff_ffff},
    '{"rst_e2", OP_RD, A_E2, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'hffff_ffff},
    '{"rst_e3", OP_RD, A_E3, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'hffff_ffff},
    '{"wr_d0_full", OP_WR, A_D0, 32'h1234_5678, 4'hf, 128'h0, RSP_OK, 1'b0, 32'h0},
    '{"wr_d0_byte1", OP_WR, A_D0, 32'haabb_ccdd, 4'h2, 128'h0, RSP_OK, 1'b0, 32'h0},
    '{"rd_d0_byte1", OP_RD, A_D0, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'h1234_cc78},
    '{"wr_e0_bytes02", OP_WR, A_E0, 32'h1122_3344, 4'h5, 128'h0, RSP_OK, 1'b0, 32'h0},
    '{"rd_e0_ignores_in", OP_RD, A_E0, 32'h0, 4'h0, '1, RSP_OK, 1'b1, 32'hff22_ff44},
    '{"mix_d0", OP_RD, A_D0, 32'h0, 4'h0, 128'hf0f0_f0f0, RSP_OK, 1'b1, 32'hf234_fc78},
    '{"wr_e2_zero", OP_WR, A_E2, 32'h0, 4'hf, 128'h0, RSP_OK, 1'b0, 32'h0},
    '{"mix_d2_masked", OP_RD, A_D2, 32'h0, 4'h0, 128'hffff_ffff_0000_0000_0000_0000,
        RSP_OK, 1'b1, 32'h0},
    '{"wr_d3_byte3", OP_WR, A_D3, 32'h5a00_0000, 4'h8, 128'h0, RSP_OK, 1'b0, 32'h0},
    '{"wr_e3_bytes13", OP_WR, A_E3, 32'h0f00_f000, 4'ha, 128'h0, RSP_OK, 1'b0, 32'h0},
    '{"mix_d3", OP_RD, A_D3, 32'h0, 4'h0, {32'h00ff_ff00, 96'h0},
        RSP_OK, 1'b1, 32'h5aff_f000},
    '{"err_base_wr", OP_WR, 32'h2300_0000, 32'hffff_ffff, 4'hf, 128'h0,
        RSP_ERR, 1'b0, 32'h0},
    '{"err_ofs20_wr", OP_WR, A_D0 + 32'h20, 32'hffff_ffff, 4'hf, 128'h0,
        RSP_ERR, 1'b0, 32'h0},
    '{"err_ofs05_rd", OP_RD, A_D0 + 32'h05, 32'h0, 4'h0, 128'h0, RSP_ERR, 1'b1, 32'h0},
    '{"err_base_rd", OP_RD, A_D0 + 32'h100, 32'h0, 4'h0, 128'h0, RSP_ERR, 1'b1, 32'h0},
    '{"rd_d0_after_err", OP_RD, A_D0, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'h1234_cc78},
    '{"wr_d1_byte0", OP_WR, A_D1, 32'h0000_00ee, 4'h1, 128'h0, RSP_OK, 1'b0, 32'h0},
    '{"rd_d1", OP_RD, A_D1, 32'h0, 4'h0, 128'h0000_1100_0000_0000,
        RSP_OK, 1'b1, 32'h0000_11ee},
    '{"wr_e1_no_strb", OP_WR, A_E1, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b0, 32'h0},
    '{"rd_e1", OP_RD, A_E1, 32'h0, 4'h0, 128'h0, RSP_OK, 1'b1, 32'hffff_ffff}
};

`endif

// ==== test/la_tb.sv ====
// Logic analyzer testbench
`timescale 1ns/1ps
`include "la_cfg.svh"

module la_tb;

    localparam int CLK_PERIOD = 100;
    localparam la_pkg::addr_t BASE = `LA_BASE_ADR;

    `include "la_tb_table.svh"

    logic              clk;
    logic              resetn;
    la_pkg::addr_t     s_awaddr;
    logic              s_awvalid;
    logic              s_awready;
    la_pkg::word_t     s_wdata;
    la_pkg::strb_t     s_wstrb;
    logic              s_wvalid;
    logic              s_wready;
    la_pkg::axi_resp_t s_bresp;
    logic              s_bvalid;
    logic              s_bready;
    la_pkg::addr_t     s_araddr;
    logic              s_arvalid;
    logic              s_arready;
    la_pkg::word_t     s_rdata;
    la_pkg::axi_resp_t s_rresp;
    logic              s_rvalid;
    logic              s_rready;
    la_pkg::probe_t    probe_in;
    la_pkg::probe_t    probe_data;
    la_pkg::probe_t    probe_oen;

    logic [31:0]       lfsr_q;
    // Reference copy of the eight registers
    la_pkg::word_t     m_data [4];
    la_pkg::word_t     m_ena [4];

    la_top i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .s_awaddr_i   (s_awaddr),
        .s_awvalid_i  (s_awvalid),
        .s_awready_o  (s_awready),
        .s_wdata_i    (s_wdata),
        .s_wstrb_i    (s_wstrb),
        .s_wvalid_i   (s_wvalid),
        .s_wready_o   (s_wready),
        .s_bresp_o    (s_bresp),
        .s_bvalid_o   (s_bvalid),
        .s_bready_i   (s_bready),
        .s_araddr_i   (s_araddr),
        .s_arvalid_i  (s_arvalid),
        .s_arready_o  (s_arready),
        .s_rdata_o    (s_rdata),
        .s_rresp_o    (s_rresp),
        .s_rvalid_o   (s_rvalid),
        .s_rready_i   (s_rready),
        .probe_in_i   (probe_in),
        .probe_data_o (probe_data),
        .probe_oen_o  (probe_oen)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [127:0] exp, input logic [127:0] act);
        assert (act === exp) else begin
            $display("mismatch %s %s: expected %h, actual %h", test, what, exp, act);
            report_failure();
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic bit random_bit();
        bit b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        return b;
    endfunction

    function automatic int random_hold();
        int n;
        n = random_bit();
        n = 2 * n + random_bit();
        return n;
    endfunction

    // Offsets 00 to 1c in steps of 4 inside the window
    function automatic bit model_hit(input la_pkg::addr_t a);
        return (a[31:8] == BASE[31:8]) && (a[7:5] == 3'b000) && (a[1:0] == 2'b00);
    endfunction

    task automatic model_write(input la_pkg::addr_t a, input la_pkg::word_t d,
                               input la_pkg::strb_t s);
        if (model_hit(a)) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b] && a[4]) m_ena[a[3:2]][8*b +: 8] = d[8*b +: 8];
                if (s[b] && !a[4]) m_data[a[3:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    function automatic la_pkg::word_t model_read(input la_pkg::addr_t a,
                                                 input la_pkg::probe_t p);
        la_pkg::word_t slice;
        slice = p[32 * a[3:2] +: 32];
        if (!model_hit(a)) return '0;
        if (a[4]) return m_ena[a[3:2]];
        return m_data[a[3:2]] | (slice & m_ena[a[3:2]]);
    endfunction

    // Entered and left just after a rising edge
    task automatic axi_write(input la_pkg::addr_t a, input la_pkg::word_t d,
                             input la_pkg::strb_t s, output la_pkg::axi_resp_t resp);
        int hold;
        s_awaddr  = a;
        s_wdata   = d;
        s_wstrb   = s;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        do @(negedge clk); while (!(s_awready && s_wready));
        @(posedge clk);
        #1;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid) begin
            @(posedge clk);
            #1;
        end
        hold = random_hold();
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        assert (s_bvalid) else begin
            $display("write response dropped before bready was raised");
            report_failure();
        end
        s_bready = 1'b1;
        resp = s_bresp;
        @(posedge clk);
        #1;
        s_bready = 1'b0;
        assert (!s_bvalid) else begin
            $display("write response still valid after it was taken");
            report_failure();
        end
    endtask

    task automatic axi_read(input la_pkg::addr_t a, output la_pkg::word_t d,
                            output la_pkg::axi_resp_t resp);
        int hold;
        s_araddr  = a;
        s_arvalid = 1'b1;
        do @(negedge clk); while (!s_arready);
        @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        while (!s_rvalid) begin
            @(posedge clk);
            #1;
        end
        hold = random_hold();
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        assert (s_rvalid) else begin
            $display("read response dropped before rready was raised");
            report_failure();
        end
        s_rready = 1'b1;
        resp = s_rresp;
        d = s_rdata;
        @(posedge clk);
        #1;
        s_rready = 1'b0;
        assert (!s_rvalid) else begin
            $display("read response still valid after it was taken");
            report_failure();
        end
    endtask

    initial begin
        la_pkg::axi_resp_t resp;
        la_pkg::word_t     rdata;
        resetn    = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        probe_in  = '0;
        lfsr_q    = 32'h833c02a5;
        for (int i = 0; i < 4; i++) begin
            m_data[i] = '0;
            m_ena[i]  = `LA_ENA_RESET;
        end
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;

        check_value("reset", "probe_data_o", '0, probe_data);
        check_value("reset", "probe_oen_o", {4{`LA_ENA_RESET}}, probe_oen);
        check_value("reset", "bvalid", 1'b0, s_bvalid);
        check_value("reset", "rvalid", 1'b0, s_rvalid);

        for (int i = 0; i < NUM_ROWS; i++) begin
            probe_in = rows[i].probe;
            if (rows[i].op == OP_WR) begin
                axi_write(rows[i].addr, rows[i].wdata, rows[i].strb, resp);
                model_write(rows[i].addr, rows[i].wdata, rows[i].strb);
            end else begin
                axi_read(rows[i].addr, rdata, resp);
                check_value(rows[i].name, "rdata from model",
                            model_read(rows[i].addr, rows[i].probe), rdata);
                if (rows[i].chk) begin
                    check_value(rows[i].name, "rdata", rows[i].rdata, rdata);
                end
            end
            check_value(rows[i].name, "resp", rows[i].resp, resp);
            check_value(rows[i].name, "probe_data_o",
                        {m_data[3], m_data[2], m_data[1], m_data[0]}, probe_data);
            check_value(rows[i].name, "probe_oen_o",
                        {m_ena[3], m_ena[2], m_ena[1], m_ena[0]}, probe_oen);
        end

        $display("All checks passed");
        $finish;
    end

    // Watchdog sized from the table length plus reset
    initial begin
        #((NUM_ROWS * 20 + 2) * CLK_PERIOD);
        $display("timeout: the table did not complete in the expected time");
        report_failure();
    end

endmodule

// ==== list.f ====
+incdir+source
+incdir+test
source/la_pkg.sv
source/axil_la_slave.sv
source/la_regs.sv
source/la_top.sv
test/la_tb.sv
